// ==== source/rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

	localparam int instrWidth = 32;
	localparam int regAddrWidth = 5;

	// Major opcodes kept by the core
	localparam logic [6:0] opR = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;

	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll = 3'b001;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3SrlSra = 3'b101;
	localparam logic [2:0] f3And = 3'b111;
	localparam logic [2:0] f3Word = 3'b010; // lw and sw
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [2:0] f3Blt = 3'b100;
	localparam logic [2:0] f3Bge = 3'b101;

	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Alt = 7'b0100000; // sub
	localparam logic [5:0] f6ShiftLogic = 6'b000000;
	localparam logic [5:0] f6ShiftArith = 6'b010000; // srai

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluSlt, aluSll, aluSrl, aluSra} aluOp_t;
	typedef enum logic {srcAPc, srcARegA} srcASel_t;
	typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBBranch} srcBSel_t;
	typedef enum logic {wbAluOut, wbMdr} wbSel_t;
	typedef enum logic [1:0] {immI, immS, immB} immKind_t;

	typedef enum logic [2:0] {
		stFetch, stDecode, stExecute, stWriteback,
		stMemAddr, stMemRead, stMemWrite, stBranch
	} state_t;

	typedef struct packed {
		logic pcWrite;
		logic irWrite;
		logic regWrite;
		logic loadOperands; // A and B registers
		logic loadAluOut;
		logic loadMdr;
		logic memRead;
		logic memWrite;
		logic memAddrFromAlu; // Else PC drives the address
		aluOp_t aluOp;
		srcASel_t srcA;
		srcBSel_t srcB;
		wbSel_t wbSel;
		immKind_t immKind;
	} ctrlSigs_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [regAddrWidth-1:0] rs2;
		logic [regAddrWidth-1:0] rs1;
		logic [2:0] funct3;
		logic [regAddrWidth-1:0] rd;
		logic [6:0] opcode;
	} rView_t;

	// rd slot doubles as imm[4:0] for stores
	typedef struct packed {
		logic [11:0] imm12;
		logic [regAddrWidth-1:0] rs1;
		logic [2:0] funct3;
		logic [regAddrWidth-1:0] rd;
		logic [6:0] opcode;
	} iView_t;

	typedef union packed {
		rView_t r;
		iView_t i;
	} instrWord_u;

	// Memory request, declared per user with its own dataWidth
	// Field order, msb first: read, write, addr[dataWidth], wdata[dataWidth]

endpackage

`default_nettype wire

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit import rvCorePkg::*; #(
	parameter int dataWidth = 32
) (
	input wire logic [dataWidth-1:0] a,
	input wire logic [dataWidth-1:0] b,
	input wire aluOp_t op,
	output logic [dataWidth-1:0] result,
	output logic zero,
	output logic less
);

	localparam int shWidth = $clog2(dataWidth);

	logic [shWidth-1:0] shamt;

	assign shamt = b[shWidth-1:0]; // Low bits of the immediate field
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluSlt: result = {{(dataWidth-1){1'b0}}, less};
			aluSll: result = a << shamt;
			aluSrl: result = a >> shamt;
			aluSra: result = $signed(a) >>> shamt; // Sign fill
			default: result = a + b;
		endcase
	end

	assign zero = result == '0; // Equal operands after sub

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import rvCorePkg::*; #(
	parameter int dataWidth = 32
) (
	input wire logic rst,
	input wire logic clk,
	input wire logic [regAddrWidth-1:0] rs1,
	input wire logic [regAddrWidth-1:0] rs2,
	input wire logic [regAddrWidth-1:0] rd,
	input wire logic we,
	input wire logic [dataWidth-1:0] wdata,
	output logic [dataWidth-1:0] rdata1,
	output logic [dataWidth-1:0] rdata2
);

	logic [dataWidth-1:0] regs [2**regAddrWidth];

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			for (int i = 0; i < 2**regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wdata; // x0 never written, stays zero
		end
	end

	assign rdata1 = regs[rs1];
	assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

// ==== source/immGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module immGen import rvCorePkg::*; #(
	parameter int dataWidth = 32
) (
	input wire instrWord_u instr,
	input wire immKind_t kind,
	output logic [dataWidth-1:0] imm
);

	logic [11:0] immIRaw;
	logic [11:0] immSRaw;
	logic [12:0] immBRaw;

	assign immIRaw = instr.i.imm12;
	// Store splits its offset around rs2 and rs1
	assign immSRaw = {instr.i.imm12[11:5], instr.i.rd};
	assign immBRaw = {instr.i.imm12[11], instr.i.rd[0], instr.i.imm12[10:5],
		instr.i.rd[4:1], 1'b0};

	always_comb begin
		case (kind)
			immS: imm = {{(dataWidth-12){immSRaw[11]}}, immSRaw};
			immB: imm = {{(dataWidth-13){immBRaw[12]}}, immBRaw}; // Halfword offset
			default: imm = {{(dataWidth-12){immIRaw[11]}}, immIRaw};
		endcase
	end

endmodule

`default_nettype wire

// ==== source/controlFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlFsm import rvCorePkg::*; (
	input wire logic rst,
	input wire logic clk,
	input wire instrWord_u instr,
	input wire logic aluZero,
	input wire logic aluLess,
	output ctrlSigs_t ctrl
);

	state_t state;
	state_t nextState;
	logic running; // Low only in the cycle after reset release
	logic legal;
	logic isShift;
	logic taken;
	aluOp_t execOp;
	immKind_t immKind;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			state <= stFetch;
			running <= 1'b0;
		end else begin
			state <= nextState;
			running <= 1'b1;
		end
	end

	// Instruction decode, unknown encodings fall out as illegal
	always_comb begin
		legal = 1'b0;
		isShift = 1'b0;
		execOp = aluAdd;
		case (instr.r.opcode)
			opR: begin
				if (instr.r.funct7 == f7Base) begin
					case (instr.r.funct3)
						f3AddSub: legal = 1'b1;
						f3Slt: begin
							legal = 1'b1;
							execOp = aluSlt;
						end
						f3And: begin
							legal = 1'b1;
							execOp = aluAnd;
						end
						default: legal = 1'b0;
					endcase
				end else if (instr.r.funct7 == f7Alt && instr.r.funct3 == f3AddSub) begin
					legal = 1'b1;
					execOp = aluSub;
				end
			end
			opImm: begin
				case (instr.i.funct3)
					f3AddSub: legal = 1'b1; // addi
					f3Slt: begin
						legal = 1'b1;
						execOp = aluSlt;
					end
					f3Sll: begin
						legal = instr.i.imm12[11:6] == f6ShiftLogic;
						isShift = 1'b1;
						execOp = aluSll;
					end
					f3SrlSra: begin
						legal = instr.i.imm12[11:6] == f6ShiftLogic ||
							instr.i.imm12[11:6] == f6ShiftArith;
						isShift = 1'b1;
						if (instr.i.imm12[10]) begin
							execOp = aluSra;
						end else begin
							execOp = aluSrl;
						end
					end
					default: legal = 1'b0;
				endcase
			end
			opLoad, opStore: legal = instr.i.funct3 == f3Word;
			opBranch: begin
				legal = instr.i.funct3 == f3Beq || instr.i.funct3 == f3Bne ||
					instr.i.funct3 == f3Blt || instr.i.funct3 == f3Bge;
			end
			default: legal = 1'b0;
		endcase
	end

	always_comb begin
		case (instr.i.opcode)
			opStore: immKind = immS;
			opBranch: immKind = immB;
			default: immKind = immI;
		endcase
	end

	// Branch outcome from the compare done in the branch state
	always_comb begin
		case (instr.i.funct3)
			f3Beq: taken = aluZero;
			f3Bne: taken = !aluZero;
			f3Blt: taken = aluLess;
			f3Bge: taken = !aluLess;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.immKind = immKind;
		nextState = state;
		case (state)
			stFetch: begin
				if (running) begin
					ctrl.memRead = 1'b1;
					ctrl.irWrite = 1'b1;
					ctrl.pcWrite = 1'b1; // PC + 4 from the ALU
					ctrl.srcA = srcAPc;
					ctrl.srcB = srcBFour;
					nextState = stDecode;
				end
			end
			stDecode: begin
				ctrl.loadOperands = 1'b1;
				ctrl.loadAluOut = 1'b1; // Branch target, harmless for the rest
				ctrl.srcA = srcAPc;
				ctrl.srcB = srcBBranch;
				if (!legal) begin
					nextState = stFetch;
				end else if (instr.i.opcode == opLoad || instr.i.opcode == opStore) begin
					nextState = stMemAddr;
				end else if (instr.i.opcode == opBranch) begin
					nextState = stBranch;
				end else begin
					nextState = stExecute;
				end
			end
			stExecute: begin
				ctrl.srcA = srcARegA;
				if (instr.r.opcode == opR) begin
					ctrl.srcB = srcBRegB;
				end else begin
					ctrl.srcB = srcBImm;
				end
				ctrl.aluOp = execOp;
				ctrl.loadAluOut = 1'b1;
				if (isShift) begin
					ctrl.regWrite = 1'b1; // Shifts write back in the same cycle
					nextState = stFetch;
				end else begin
					nextState = stWriteback;
				end
			end
			stWriteback: begin
				ctrl.regWrite = 1'b1;
				if (instr.i.opcode == opLoad) begin
					ctrl.wbSel = wbMdr;
				end else begin
					ctrl.wbSel = wbAluOut;
				end
				nextState = stFetch;
			end
			stMemAddr: begin
				ctrl.srcA = srcARegA;
				ctrl.srcB = srcBImm;
				ctrl.loadAluOut = 1'b1;
				if (instr.i.opcode == opLoad) begin
					nextState = stMemRead;
				end else begin
					nextState = stMemWrite;
				end
			end
			stMemRead: begin
				ctrl.memRead = 1'b1;
				ctrl.memAddrFromAlu = 1'b1;
				ctrl.loadMdr = 1'b1;
				nextState = stWriteback;
			end
			stMemWrite: begin
				ctrl.memWrite = 1'b1;
				ctrl.memAddrFromAlu = 1'b1;
				nextState = stFetch;
			end
			stBranch: begin
				ctrl.srcA = srcARegA;
				ctrl.srcB = srcBRegB;
				ctrl.aluOp = aluSub;
				ctrl.pcWrite = taken; // Target already sits in ALU-result reg
				nextState = stFetch;
			end
			default: nextState = stFetch;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/coreDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreDatapath import rvCorePkg::*; #(
	parameter int dataWidth = 32,
	localparam type memReq_t = struct packed {
		logic read;
		logic write;
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
	}
) (
	input wire logic rst,
	input wire logic clk,
	input wire ctrlSigs_t ctrl,
	input wire logic [dataWidth-1:0] memRdata,
	output instrWord_u instr,
	output logic aluZero,
	output logic aluLess,
	output memReq_t memReq
);

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] regA;
	logic [dataWidth-1:0] regB;
	logic [dataWidth-1:0] aluOutReg;
	logic [dataWidth-1:0] mdr;
	logic [dataWidth-1:0] rdata1;
	logic [dataWidth-1:0] rdata2;
	logic [dataWidth-1:0] imm;
	logic [dataWidth-1:0] aluA;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] wbData;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			pc <= '0;
		end else if (ctrl.pcWrite) begin
			// Fetch takes PC + 4 straight from the ALU, a taken branch the saved target
			pc <= ctrl.irWrite ? aluResult : aluOutReg;
		end
	end

	always_ff @(posedge rst) begin
		if (ctrl.irWrite) begin
			instr <= memRdata[instrWidth-1:0];
		end
		if (ctrl.loadOperands) begin
			regA <= rdata1;
			regB <= rdata2;
		end
		if (ctrl.loadAluOut) begin
			aluOutReg <= aluResult;
		end
		if (ctrl.loadMdr) begin
			mdr <= memRdata;
		end
	end

	assign aluA = (ctrl.srcA == srcAPc) ? pc : regA;

	always_comb begin
		case (ctrl.srcB)
			srcBRegB: aluB = regB;
			srcBFour: aluB = dataWidth'(4);
			srcBImm: aluB = imm;
			default: aluB = imm - dataWidth'(4); // PC is already advanced in decode
		endcase
	end

	// Bypass when the result register loads this cycle
	always_comb begin
		if (ctrl.wbSel == wbMdr) begin
			wbData = mdr;
		end else if (ctrl.loadAluOut) begin
			wbData = aluResult;
		end else begin
			wbData = aluOutReg;
		end
	end

	assign memReq.read = ctrl.memRead;
	assign memReq.write = ctrl.memWrite;
	assign memReq.addr = ctrl.memAddrFromAlu ? aluOutReg : pc;
	assign memReq.wdata = regB;

	regFile #(.dataWidth(dataWidth)) u_regFile (
		.rst(rst),
		.clk(clk),
		.rs1(instr.r.rs1),
		.rs2(instr.r.rs2),
		.rd(instr.r.rd),
		.we(ctrl.regWrite),
		.wdata(wbData),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	immGen #(.dataWidth(dataWidth)) u_immGen (
		.instr(instr),
		.kind(ctrl.immKind),
		.imm(imm)
	);

	aluUnit #(.dataWidth(dataWidth)) u_aluUnit (
		.a(aluA),
		.b(aluB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.zero(aluZero),
		.less(aluLess)
	);

endmodule

`default_nettype wire

// ==== source/multicycleCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module multicycleCore import rvCorePkg::*; #(
	parameter int dataWidth = 32,
	localparam type memReq_t = struct packed {
		logic read;
		logic write;
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
	}
) (
	input wire logic rst,
	input wire logic clk,
	input wire logic [dataWidth-1:0] memRdata,
	output memReq_t memReq
);

	ctrlSigs_t ctrl;
	instrWord_u instr; // Instruction register, decoded by the FSM
	logic aluZero;
	logic aluLess;

	controlFsm u_controlFsm (
		.rst(rst),
		.clk(clk),
		.instr(instr),
		.aluZero(aluZero),
		.aluLess(aluLess),
		.ctrl(ctrl)
	);

	coreDatapath #(.dataWidth(dataWidth)) u_coreDatapath (
		.rst(rst),
		.clk(clk),
		.ctrl(ctrl),
		.memRdata(memRdata),
		.instr(instr),
		.aluZero(aluZero),
		.aluLess(aluLess),
		.memReq(memReq)
	);

endmodule

`default_nettype wire

// ==== verif/controlFsm_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlFsm_sva import rvCorePkg::*; (
	input wire logic rst,
	input wire logic clk,
	input wire state_t state,
	input wire ctrlSigs_t ctrl
);

	// One memory port, so one strobe at a time
	memStrobesExclusive: assert property (@(posedge rst) disable iff (clk)
		!(ctrl.memRead && ctrl.memWrite))
		else $error("memRead and memWrite are high in the same cycle");

	decodeAfterFetch: assert property (@(posedge rst) disable iff (clk)
		(state == stFetch && ctrl.irWrite) |=> state == stDecode)
		else $error("a fetch was not followed by decode");

	noEarlyRegWrite: assert property (@(posedge rst) disable iff (clk)
		(state == stFetch || state == stDecode) |-> !ctrl.regWrite)
		else $error("register write seen during fetch or decode");

endmodule

`default_nettype wire

// ==== verif/coreChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreChecker (
	input wire logic rst,
	input wire logic clk,
	input wire logic memRead,
	input wire logic memWrite,
	input wire logic [31:0] memAddr,
	input wire logic [31:0] memWdata,
	input wire logic [31:0] memRdata,
	output logic done,
	output int errors,
	output int retired
);

	logic [31:0] regs [32];
	logic [31:0] dataMem [logic [31:0]]; // Only words the model has stored
	logic [31:0] pc;
	logic [31:0] loadAddr;
	logic [31:0] storeAddr;
	logic [31:0] storeData;
	bit loadPending;
	bit storePending;
	bit started;
	int sinceFetch;
	int expectCycles;
	int loopFetches;

	// Same address hash as the memory image in the testbench
	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return (addr * 32'h9E37_79B1) ^ 32'hC3C3_5A5A;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s: expected 'h%0h, actual 'h%0h (model pc 'h%0h)",
				name, expected, actual, pc);
		end
	endtask

	task automatic writeReg(input logic [4:0] rd, input logic [31:0] value);
		if (rd != 5'd0) begin
			regs[rd] = value; // x0 stays zero
		end
	endtask

	// Instruction-level step that also sets the cycle count of the class
	task automatic execute(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] nextPc;
		bit taken;
		a = regs[w[19:15]];
		b = regs[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		nextPc = pc + 32'd4;
		taken = 1'b0;
		expectCycles = 2; // Unknown encoding goes decode then fetch
		case (w[6:0])
			7'b0110011: begin
				expectCycles = 4;
				case ({w[31:25], w[14:12]})
					{7'h00, 3'b000}: writeReg(w[11:7], a + b);
					{7'h20, 3'b000}: writeReg(w[11:7], a - b);
					{7'h00, 3'b111}: writeReg(w[11:7], a & b);
					{7'h00, 3'b010}: writeReg(w[11:7], {31'd0, $signed(a) < $signed(b)});
					default: expectCycles = 2;
				endcase
			end
			7'b0010011: begin
				case (w[14:12])
					3'b000: begin
						expectCycles = 4;
						writeReg(w[11:7], a + immI);
					end
					3'b010: begin
						expectCycles = 4;
						writeReg(w[11:7], {31'd0, $signed(a) < $signed(immI)});
					end
					3'b001: begin
						if (w[31:25] == 7'h00) begin
							expectCycles = 3;
							writeReg(w[11:7], a << w[24:20]);
						end
					end
					3'b101: begin
						if (w[31:25] == 7'h00) begin
							expectCycles = 3;
							writeReg(w[11:7], a >> w[24:20]);
						end else if (w[31:25] == 7'h20) begin
							expectCycles = 3;
							writeReg(w[11:7], $unsigned($signed(a) >>> w[24:20]));
						end
					end
					default: expectCycles = 2;
				endcase
			end
			7'b0000011: begin
				if (w[14:12] == 3'b010) begin
					expectCycles = 5;
					loadAddr = a + immI;
					loadPending = 1'b1;
					writeReg(w[11:7], dataMem.exists(loadAddr) ? dataMem[loadAddr] :
						fillWord(loadAddr));
				end
			end
			7'b0100011: begin
				if (w[14:12] == 3'b010) begin
					expectCycles = 4;
					storeAddr = a + immS;
					storeData = b;
					storePending = 1'b1;
					dataMem[storeAddr] = b;
				end
			end
			7'b1100011: begin
				expectCycles = 3;
				case (w[14:12])
					3'b000: taken = a == b;
					3'b001: taken = a != b;
					3'b100: taken = $signed(a) < $signed(b);
					3'b101: taken = $signed(a) >= $signed(b);
					default: expectCycles = 2;
				endcase
				if (taken) begin
					nextPc = pc + immB;
				end
			end
			default: expectCycles = 2;
		endcase
		pc = nextPc;
	endtask

	always @(posedge rst) begin
		if (clk) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] = 32'd0;
			end
			dataMem.delete();
			pc = 32'd0;
			loadPending = 1'b0;
			storePending = 1'b0;
			started = 1'b0;
			sinceFetch = 0;
			expectCycles = 0;
			loopFetches = 0;
			done = 1'b0;
			errors = 0;
			retired = 0;
		end else begin
			if (memWrite) begin
				if (!storePending) begin
					errors++;
					$display("Unexpected store of 'h%0h to address 'h%0h", memWdata, memAddr);
				end else begin
					checkValue("store address", storeAddr, memAddr);
					checkValue("store data", storeData, memWdata);
					storePending = 1'b0;
				end
			end
			if (memRead && loadPending) begin
				checkValue("load address", loadAddr, memAddr);
				loadPending = 1'b0;
				sinceFetch++;
			end else if (memRead) begin
				if (storePending) begin
					errors++;
					$display("Store expected at address 'h%0h was never issued", storeAddr);
					storePending = 1'b0;
				end
				if (started) begin
					checkValue("cycle count", 32'(expectCycles), 32'(sinceFetch));
				end
				checkValue("fetch address", pc, memAddr);
				started = 1'b1;
				sinceFetch = 1;
				retired++;
				if (memRdata == 32'h0000_0063) begin // beq x0,x0,0
					loopFetches++;
					done = loopFetches >= 2;
				end
				execute(memRdata);
			end else if (started) begin
				sinceFetch++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/coreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreTb;

	localparam int memWords = 1024; // 4 KiB, word index is addr[11:2]
	localparam int randCount = 60;
	localparam int dataBase = 'h400;
	localparam int dumpBase = 'h600;
	localparam int timeoutCycles = 20000;
	localparam logic [2:0] branchF3 [4] = '{3'b000, 3'b001, 3'b100, 3'b101};

	typedef struct packed {
		logic read;
		logic write;
		logic [31:0] addr;
		logic [31:0] wdata;
	} memBus_t;

	logic rst; // Clock
	logic clk; // Reset, active high
	logic [31:0] memRdata;
	memBus_t memReq;
	logic [31:0] mem [memWords];
	integer seed;
	logic done;
	int errors;
	int retired;
	int cycles;

	bind controlFsm controlFsm_sva u_controlFsmSva (
		.rst(rst),
		.clk(clk),
		.state(state),
		.ctrl(ctrl)
	);

	multicycleCore #(.dataWidth(32)) u_multicycleCore (
		.rst(rst),
		.clk(clk),
		.memRdata(memRdata),
		.memReq(memReq)
	);

	coreChecker u_coreChecker (
		.rst(rst),
		.clk(clk),
		.memRead(memReq.read),
		.memWrite(memReq.write),
		.memAddr(memReq.addr),
		.memWdata(memReq.wdata),
		.memRdata(memRdata),
		.done(done),
		.errors(errors),
		.retired(retired)
	);

	initial begin
		rst = 1'b0;
		forever #4 rst = ~rst;
	end

	assign memRdata = mem[memReq.addr[11:2]]; // Same-cycle read

	always @(posedge rst) begin
		if (memReq.write) begin
			mem[memReq.addr[11:2]] <= memReq.wdata;
		end
	end

	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return (addr * 32'h9E37_79B1) ^ 32'hC3C3_5A5A;
	endfunction

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % $unsigned(n));
	endfunction

	function automatic logic [11:0] dataOffset();
		return 12'(dataBase + 4 * randBelow(64)); // Word aligned, off x0
	endfunction

	function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encodeB(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	// Random body, register dump, then the closing self-loop
	task automatic buildProgram();
		int k;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		for (int a = 0; a < memWords; a++) begin
			mem[a] = fillWord(32'(a * 4));
		end
		for (int i = 0; i < randCount; i++) begin
			rd = 5'(randBelow(32));
			rs1 = 5'(randBelow(32));
			rs2 = 5'(randBelow(32));
			case (randBelow(13))
				0: mem[i] = encodeR(7'h00, rs2, rs1, 3'b000, rd);
				1: mem[i] = encodeR(7'h20, rs2, rs1, 3'b000, rd);
				2: mem[i] = encodeR(7'h00, rs2, rs1, 3'b111, rd);
				3: mem[i] = encodeR(7'h00, rs2, rs1, 3'b010, rd);
				4, 5: mem[i] = encodeI(12'($random(seed)), rs1, 3'b000, rd, 7'b0010011);
				6: mem[i] = encodeI(12'($random(seed)), rs1, 3'b010, rd, 7'b0010011);
				7: mem[i] = encodeI({7'h00, rs2}, rs1, 3'b001, rd, 7'b0010011);
				8: mem[i] = encodeI({7'h00, rs2}, rs1, 3'b101, rd, 7'b0010011);
				9: mem[i] = encodeI({7'h20, rs2}, rs1, 3'b101, rd, 7'b0010011);
				10: mem[i] = encodeI(dataOffset(), 5'd0, 3'b010, rd, 7'b0000011);
				11: mem[i] = encodeS(dataOffset(), rs2, 5'd0);
				default: begin
					k = 1 + randBelow(4); // Forward only, never past the body
					if (i + k > randCount) begin
						k = randCount - i;
					end
					mem[i] = encodeB(13'(4 * k), rs2, rs1, branchF3[randBelow(4)]);
				end
			endcase
		end
		for (int r = 1; r < 32; r++) begin
			mem[randCount + r - 1] = encodeS(12'(dumpBase + 4 * (r - 1)), 5'(r), 5'd0);
		end
		mem[randCount + 31] = encodeB(13'd0, 5'd0, 5'd0, 3'b000);
	endtask

	initial begin
		seed = 74;
		clk = 1'b1;
		buildProgram();
		repeat (16) @(negedge rst);
		clk = 1'b0;
		cycles = 0;
		while (!done && cycles < timeoutCycles) begin
			@(negedge rst);
			cycles++;
		end
		$display("Summary: %0d errors, %0d fetches checked, %0d cycles", errors, retired, cycles);
		if (!done) begin
			$display("Timeout: the core never fetched the final self-loop twice");
			$display(">>> FAIL");
		end else if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/rvCorePkg.sv
source/aluUnit.sv
source/regFile.sv
source/immGen.sv
source/controlFsm.sv
source/coreDatapath.sv
source/multicycleCore.sv
verif/controlFsm_sva.sv
verif/coreChecker.sv
verif/coreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= coreTb
FLIST ?= flist.f
OBJDIR ?= obj_dir
LOG ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q ">>> FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
